// File: logic/bank_if.sv
/*
 * Controller to main memory link
 * One word access per cycle, read data after a fixed latency
 */
`default_nettype none
`timescale 1ns/100ps

interface bank_if
   import cache_geom_pkg::*;
();

   addr_t addr;
   data_t wdata;
   logic  wr;
   logic  rd;
   // Valid MEM_RD_LATENCY cycles after rd
   data_t rdata;

   modport master (output addr, wdata, wr, rd, input rdata);
   modport slave  (input addr, wdata, wr, rd, output rdata);

endinterface

`default_nettype wire

// File: logic/cache_array.sv
/*
 * Direct-mapped cache storage
 * Tag, valid, dirty and line data with a combinational lookup
 */
`default_nettype none
`timescale 1ns/100ps

module cache_array
   import cache_geom_pkg::*;
(
   input  logic clk,
   input  logic rst,
   cache_if.slave cif
);

   tag_t              tag_q   [NUM_LINES];
   data_t             data_q  [NUM_LINES][WORDS_PER_LINE];
   logic [NUM_LINES-1:0] valid_q;
   logic [NUM_LINES-1:0] dirty_q;

   logic install;
   logic store_word;

   // Lookup of the addressed line
   assign cif.rdata   = data_q[cif.index][cif.word];
   assign cif.tag_out = tag_q[cif.index];
   assign cif.hit     = cif.enable && valid_q[cif.index] &&
                        (tag_q[cif.index] == cif.tag_in);
   // Only a valid line can need a writeback
   assign cif.dirty   = valid_q[cif.index] && dirty_q[cif.index];

   // Install writes unconditionally, compare writes only on a hit
   assign install    = cif.enable && cif.write && !cif.comp;
   assign store_word = install || (cif.enable && cif.write && cif.comp && cif.hit);

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (install) begin
         valid_q[cif.index] <= cif.valid_in;
         // Fresh line matches memory
         dirty_q[cif.index] <= 1'b0;
      end else if (store_word) begin
         dirty_q[cif.index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (store_word) begin
         data_q[cif.index][cif.word] <= cif.wdata;
      end
      if (install) begin
         tag_q[cif.index] <= cif.tag_in;
      end
   end

endmodule

`default_nettype wire

// File: logic/cache_ctrl.sv
/*
 * Miss-handling controller
 * Hit, writeback, fill and retry sequencing with registered responses
 */
`default_nettype none
`timescale 1ns/100ps

module cache_ctrl
   import cache_geom_pkg::*;
   import cache_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      req_valid,
   input  logic      req_write,
   input  tag_t      req_tag,
   input  index_t    req_index,
   input  word_sel_t req_word,
   input  data_t     req_data,
   input  logic      req_misaligned,
   output logic      busy,
   cache_if.master   cif,
   bank_if.master    bif,
   output data_t     data_out,
   output logic      done,
   output logic      stall,
   output logic      cache_hit,
   output logic      err
);

   ctrl_state_t state;
   ctrl_state_t next_state;
   // Beat counter for writeback and fill
   fill_step_t  step;
   fill_step_t  next_step;

   logic next_done;
   logic next_err;
   logic next_hit;
   logic load_data;

   // Busy from capture until the response cycle
   assign busy  = req_valid || (state != IDLE);
   assign stall = busy;

   always_comb begin
      next_state   = state;
      next_step    = step + fill_step_t'(1);
      next_done    = 1'b0;
      next_err     = 1'b0;
      next_hit     = 1'b0;
      load_data    = 1'b0;

      // Default is the requested word, no access
      cif.enable   = 1'b0;
      cif.comp     = 1'b0;
      cif.write    = 1'b0;
      cif.index    = req_index;
      cif.tag_in   = req_tag;
      cif.word     = req_word;
      cif.wdata    = req_data;
      cif.valid_in = 1'b0;

      bif.addr     = '0;
      bif.wdata    = '0;
      bif.wr       = 1'b0;
      bif.rd       = 1'b0;

      case (state)
         IDLE: begin
            next_step = '0;
            if (req_valid && req_misaligned) begin
               // Odd address, answer without touching anything
               next_done = 1'b1;
               next_err  = 1'b1;
            end else if (req_valid) begin
               cif.enable   = 1'b1;
               cif.comp     = 1'b1;
               cif.write    = req_write;
               cif.valid_in = 1'b1;
               if (cif.hit) begin
                  next_done = 1'b1;
                  next_hit  = 1'b1;
                  load_data = !req_write;
               end else if (cif.dirty) begin
                  next_state = WRITE_BACK;
               end else begin
                  next_state = FILL_ISSUE;
               end
            end
         end

         WRITE_BACK: begin
            // Old line goes out under its stored tag
            cif.enable = 1'b1;
            cif.word   = word_sel_t'(step);
            bif.wr     = 1'b1;
            bif.addr   = {req_index, cif.tag_out, word_sel_t'(step), 1'b0};
            bif.wdata  = cif.rdata;
            if (step == fill_step_t'(BURST_LEN - 1)) begin
               next_state = FILL_ISSUE;
               next_step  = '0;
            end
         end

         FILL_ISSUE, FILL_DRAIN: begin
            if (state == FILL_ISSUE) begin
               bif.rd   = 1'b1;
               bif.addr = {req_index, req_tag, word_sel_t'(step), 1'b0};
            end
            // Install trails the issue by the read latency
            if (step >= fill_step_t'(MEM_RD_LATENCY)) begin
               cif.enable   = 1'b1;
               cif.write    = 1'b1;
               cif.valid_in = 1'b1;
               cif.word     = word_sel_t'(step - fill_step_t'(MEM_RD_LATENCY));
               cif.wdata    = bif.rdata;
            end
            if (state == FILL_ISSUE && step == fill_step_t'(BURST_LEN - 1)) begin
               next_state = FILL_DRAIN;
            end
            if (state == FILL_DRAIN && step == fill_step_t'(FILL_STEPS - 1)) begin
               next_state = RETRY;
            end
         end

         RETRY: begin
            // Line is present now, repeat the original access
            cif.enable   = 1'b1;
            cif.comp     = 1'b1;
            cif.write    = req_write;
            cif.valid_in = 1'b1;
            next_done    = 1'b1;
            load_data    = !req_write;
            next_state   = IDLE;
         end

         default: begin
            next_state = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= IDLE;
         step      <= '0;
         done      <= 1'b0;
         err       <= 1'b0;
         cache_hit <= 1'b0;
      end else begin
         state     <= next_state;
         step      <= next_step;
         done      <= next_done;
         err       <= next_err;
         cache_hit <= next_hit;
      end
   end

   // Read data held between responses
   always_ff @(posedge clk) begin
      if (load_data) begin
         data_out <= cif.rdata;
      end
   end

endmodule

`default_nettype wire

// File: logic/cache_ctrl_pkg.sv
/*
 * Miss controller protocol
 * FSM states and burst timing for writeback and fill
 */
`default_nettype none

package cache_ctrl_pkg;

   typedef enum logic [2:0] {
      IDLE,
      WRITE_BACK,
      FILL_ISSUE,
      FILL_DRAIN,
      RETRY
   } ctrl_state_t;

   // Bank read to data, in cycles
   localparam int MEM_RD_LATENCY = 2;
   // Words per writeback or fill burst
   localparam int BURST_LEN      = 4;
   // Fill issue beats plus the drain tail
   localparam int FILL_STEPS     = BURST_LEN + MEM_RD_LATENCY;

   typedef logic [2:0] fill_step_t;

endpackage

`default_nettype wire

// File: logic/cache_geom_pkg.sv
/*
 * Cache and memory geometry
 * Address split, word size and bank layout shared by all blocks
 */
`default_nettype none

package cache_geom_pkg;

   // Byte address and word
   localparam int ADDR_W         = 16;
   localparam int DATA_W         = 16;

   // Address fields, index on top, tag below it, then word and byte bits
   localparam int INDEX_W        = 8;
   localparam int TAG_W          = 5;
   localparam int WORDS_PER_LINE = 4;
   localparam int NUM_LINES      = 2 ** INDEX_W;

   // Word-interleaved main memory
   localparam int NUM_BANKS      = 4;
   localparam int BANK_AW        = ADDR_W - $clog2(NUM_BANKS) - 1;

   typedef logic [ADDR_W-1:0]                 addr_t;
   typedef logic [DATA_W-1:0]                 data_t;
   typedef logic [TAG_W-1:0]                  tag_t;
   typedef logic [INDEX_W-1:0]                index_t;
   typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;
   typedef logic [$clog2(NUM_BANKS)-1:0]      bank_sel_t;
   typedef logic [BANK_AW-1:0]                bank_addr_t;

endpackage

`default_nettype wire

// File: logic/cache_if.sv
/*
 * Controller to cache array link
 * Compare or install accesses, with lookup results back
 */
`default_nettype none
`timescale 1ns/100ps

interface cache_if
   import cache_geom_pkg::*;
();

   // Access request
   logic      enable;
   logic      comp;
   logic      write;
   index_t    index;
   tag_t      tag_in;
   word_sel_t word;
   data_t     wdata;
   logic      valid_in;

   // Lookup result, combinational
   data_t     rdata;
   tag_t      tag_out;
   logic      hit;
   logic      dirty;

   modport master (
      output enable, comp, write, index, tag_in, word, wdata, valid_in,
      input  rdata, tag_out, hit, dirty
   );

   modport slave (
      input  enable, comp, write, index, tag_in, word, wdata, valid_in,
      output rdata, tag_out, hit, dirty
   );

endinterface

`default_nettype wire

// File: logic/four_bank_mem.sv
/*
 * Four-bank interleaved main memory
 * Word writes in one cycle, reads pipelined over two stages
 */
`default_nettype none
`timescale 1ns/100ps

module four_bank_mem
   import cache_geom_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   bank_if.slave bif
);

   // All words read as zero until written
   data_t      mem_q [NUM_BANKS][2 ** BANK_AW] = '{default: '0};

   bank_sel_t  bank;
   bank_addr_t row;

   logic       rd_valid_q;
   bank_sel_t  rd_bank_q;
   bank_addr_t rd_row_q;
   data_t      rd_data_q;

   // Word address bits 2:1 pick the bank, the rest the row
   assign bank = bif.addr[1 +: $bits(bank_sel_t)];
   assign row  = bif.addr[ADDR_W-1 -: BANK_AW];

   always_ff @(posedge clk) begin
      if (bif.wr) begin
         mem_q[bank][row] <= bif.wdata;
      end
   end

   // Stage one, bank select and row
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= bif.rd;
      end
   end

   always_ff @(posedge clk) begin
      if (bif.rd) begin
         rd_bank_q <= bank;
         rd_row_q  <= row;
      end
   end

   // Stage two, data register
   always_ff @(posedge clk) begin
      if (rd_valid_q) begin
         rd_data_q <= mem_q[rd_bank_q][rd_row_q];
      end
   end

   assign bif.rdata = rd_data_q;

endmodule

`default_nettype wire

// File: logic/mem_system.sv
/*
 * Cached memory subsystem top
 * Request decoder, miss controller, cache array and banked memory
 */
`default_nettype none
`timescale 1ns/100ps

module mem_system
   import cache_geom_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  addr_t addr,
   input  data_t data_in,
   input  logic  rd,
   input  logic  wr,
   output data_t data_out,
   output logic  done,
   output logic  stall,
   output logic  cache_hit,
   output logic  err
);

   logic      req_valid;
   logic      req_write;
   tag_t      req_tag;
   index_t    req_index;
   word_sel_t req_word;
   data_t     req_data;
   logic      req_misaligned;
   logic      busy;

   cache_if cif ();
   bank_if  bif ();

   req_decode u_req_decode (
      .clk            (clk),
      .rst            (rst),
      .addr           (addr),
      .data_in        (data_in),
      .rd             (rd),
      .wr             (wr),
      .busy           (busy),
      .req_valid      (req_valid),
      .req_write      (req_write),
      .req_tag        (req_tag),
      .req_index      (req_index),
      .req_word       (req_word),
      .req_data       (req_data),
      .req_misaligned (req_misaligned)
   );

   cache_ctrl u_cache_ctrl (
      .clk            (clk),
      .rst            (rst),
      .req_valid      (req_valid),
      .req_write      (req_write),
      .req_tag        (req_tag),
      .req_index      (req_index),
      .req_word       (req_word),
      .req_data       (req_data),
      .req_misaligned (req_misaligned),
      .busy           (busy),
      .cif            (cif.master),
      .bif            (bif.master),
      .data_out       (data_out),
      .done           (done),
      .stall          (stall),
      .cache_hit      (cache_hit),
      .err            (err)
   );

   cache_array u_cache_array (
      .clk (clk),
      .rst (rst),
      .cif (cif.slave)
   );

   four_bank_mem u_four_bank_mem (
      .clk (clk),
      .rst (rst),
      .bif (bif.slave)
   );

endmodule

`default_nettype wire

// File: logic/req_decode.sv
/*
 * Request decoder
 * Captures a read or write strobe and splits the byte address
 */
`default_nettype none
`timescale 1ns/100ps

module req_decode
   import cache_geom_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  addr_t     addr,
   input  data_t     data_in,
   input  logic      rd,
   input  logic      wr,
   input  logic      busy,
   output logic      req_valid,
   output logic      req_write,
   output tag_t      req_tag,
   output index_t    req_index,
   output word_sel_t req_word,
   output data_t     req_data,
   output logic      req_misaligned
);

   logic capture;

   // Strobes while the controller is busy are dropped
   assign capture = (rd || wr) && !busy;

   always_ff @(posedge clk) begin
      if (rst) begin
         req_valid <= 1'b0;
      end else begin
         req_valid <= capture;
      end
   end

   // Fields held until the next accepted strobe
   always_ff @(posedge clk) begin
      if (capture) begin
         req_write      <= wr;
         req_index      <= addr[ADDR_W-1 -: INDEX_W];
         req_tag        <= addr[3 +: TAG_W];
         req_word       <= addr[1 +: $bits(word_sel_t)];
         req_data       <= data_in;
         // Byte bit set means an odd address
         req_misaligned <= addr[0];
      end
   end

endmodule

`default_nettype wire

// File: sources.f
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/cache_if.sv
logic/bank_if.sv
logic/req_decode.sv
logic/cache_array.sv
logic/four_bank_mem.sv
logic/cache_ctrl.sv
logic/mem_system.sv
testbench/mem_system_assert.sv
testbench/mem_system_tb.sv

// File: testbench/mem_system_assert.sv
/*
 * Response protocol checks for the memory subsystem
 */
`default_nettype none
`timescale 1ns/100ps

module mem_system_assert
   import cache_ctrl_pkg::*;
(
   input logic clk,
   input logic rst,
   input logic done,
   input logic stall,
   input logic err
);

   // Response is a single-cycle pulse
   done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else $error("done held for more than one cycle");

   no_done_with_stall: assert property (@(posedge clk) disable iff (rst) !(done && stall))
      else $error("done and stall high together");

   // Error is part of a response
   err_only_with_done: assert property (@(posedge clk) disable iff (rst) err |-> done)
      else $error("err without done");

   stall_falls_with_done: assert property (@(posedge clk) disable iff (rst)
      $fell(stall) |-> done)
      else $error("stall dropped without done");

endmodule

bind mem_system mem_system_assert u_mem_system_assert (
   .clk   (clk),
   .rst   (rst),
   .done  (done),
   .stall (stall),
   .err   (err)
);

`default_nettype wire

// File: testbench/mem_system_tb.sv
/*
 * Memory subsystem testbench
 * Table of accesses checked against a reference memory and cache model
 */
`default_nettype none
`timescale 1ns/100ps

module mem_system_tb
   import cache_geom_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 100;

   typedef enum logic [1:0] {OP_RD, OP_WR, OP_BAD} op_t;

   typedef struct packed {
      op_t   op;
      addr_t a;
      data_t d;
      logic  hit;
      logic  err;
   } step_t;

   logic  clk;
   logic  rst;
   addr_t addr;
   data_t data_in;
   logic  rd;
   logic  wr;
   data_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   step_t steps [$];
   // Word-addressed reference memory
   data_t ref_mem [2 ** (ADDR_W - 1)];
   // Which tag each line holds
   logic  model_valid [NUM_LINES];
   tag_t  model_tag [NUM_LINES];

   mem_system DUT (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_value(input data_t actual, input data_t expected, input string what);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
         $display("TESTS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic add_step(input op_t op, input addr_t a, input data_t d,
                           input logic exp_hit, input logic exp_err);
      step_t s;
      s.op  = op;
      s.a   = a;
      s.d   = d;
      s.hit = exp_hit;
      s.err = exp_err;
      steps.push_back(s);
   endtask

   task automatic run_step(input step_t s);
      int     cycles;
      index_t idx;
      tag_t   tag;
      logic   model_hit;
      idx       = s.a[15:8];
      tag       = s.a[7:3];
      model_hit = (s.op != OP_BAD) && model_valid[idx] && (model_tag[idx] == tag);
      check_value(model_hit, s.hit, "table entry disagrees with cache model");

      // One-cycle strobe
      @(posedge clk);
      addr    <= s.a;
      data_in <= s.d;
      rd      <= (s.op != OP_WR);
      wr      <= (s.op == OP_WR);
      @(negedge clk);
      check_value(stall, 1'b0, "stall in strobe cycle");
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;

      // Count cycles after the strobe until done
      cycles = 1;
      @(negedge clk);
      while (!done) begin
         check_value(stall, 1'b1, "stall low before done");
         if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: done never came for address %h after %0d cycles", s.a, cycles);
            $display("TESTS FAILED");
            $fatal(1, "no response");
         end
         @(negedge clk);
         cycles++;
      end

      check_value(stall, 1'b0, "stall in done cycle");
      check_value(cache_hit, s.hit, "cache_hit");
      check_value(err, s.err, "err");
      // Hits and errors answer on the second edge
      if (s.hit || s.err) begin
         check_value(data_t'(cycles), 16'd2, "hit or error latency");
      end
      if (s.op == OP_RD) begin
         check_value(data_out, ref_mem[s.a[15:1]], "read data");
      end

      // Allocate on any aligned access
      if (s.op != OP_BAD) begin
         model_valid[idx] = 1'b1;
         model_tag[idx]   = tag;
      end
      if (s.op == OP_WR) begin
         ref_mem[s.a[15:1]] = s.d;
      end
   endtask

   initial begin
      rst     = 1'b1;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      foreach (ref_mem[i]) ref_mem[i] = '0;
      foreach (model_valid[i]) begin
         model_valid[i] = 1'b0;
         model_tag[i]   = '0;
      end

      // Cold miss, then neighbour word hit
      add_step(OP_RD,  16'h1208, 16'h0000, 1'b0, 1'b0);
      add_step(OP_RD,  16'h120a, 16'h0000, 1'b1, 1'b0);
      // Write miss allocates, later read hits
      add_step(OP_WR,  16'h3410, 16'hbeef, 1'b0, 1'b0);
      add_step(OP_RD,  16'h3410, 16'h0000, 1'b1, 1'b0);
      add_step(OP_WR,  16'h3416, 16'hc0de, 1'b1, 1'b0);
      // Same index, other tag, evicts the dirty line
      add_step(OP_RD,  16'h3420, 16'h0000, 1'b0, 1'b0);
      add_step(OP_RD,  16'h3410, 16'h0000, 1'b0, 1'b0);
      add_step(OP_RD,  16'h3416, 16'h0000, 1'b1, 1'b0);
      // Odd addresses leave the cache alone
      add_step(OP_BAD, 16'h3411, 16'h0000, 1'b0, 1'b1);
      add_step(OP_RD,  16'h3410, 16'h0000, 1'b1, 1'b0);
      add_step(OP_BAD, 16'h5501, 16'h0000, 1'b0, 1'b1);
      add_step(OP_RD,  16'h5500, 16'h0000, 1'b0, 1'b0);

      repeat (5) @(posedge clk);
      rst <= 1'b0;

      // Outputs quiet after reset
      @(negedge clk);
      check_value(done, 1'b0, "done after reset");
      check_value(stall, 1'b0, "stall after reset");
      check_value(cache_hit, 1'b0, "cache_hit after reset");
      check_value(err, 1'b0, "err after reset");

      foreach (steps[i]) begin
         run_step(steps[i]);
      end

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
